// ==== src/sv32_pkg.sv ====
// Sv32 translation definitions
package sv32_pkg;

    localparam int XLEN        = 32;
    localparam int PPN_W       = 20;
    localparam int VPN_W       = 10;
    localparam int PAGE_OFS_W  = 12;
    localparam int TLB_ENTRIES = 8;

    // page-fault exception codes
    localparam logic [3:0] CAUSE_FETCH_PF = 4'd12;
    localparam logic [3:0] CAUSE_LOAD_PF  = 4'd13;
    localparam logic [3:0] CAUSE_STORE_PF = 4'd15;

    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_e;

    // hypervisor level is not implemented
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef struct packed {
        logic [1:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    typedef struct packed {
        logic [VPN_W-1:0]      vpn1;
        logic [VPN_W-1:0]      vpn0;
        logic [PAGE_OFS_W-1:0] offset;
    } vaddr_t;

endpackage

// ==== src/mmu_bus_pkg.sv ====
// MMU request, response, CSR and APB types
package mmu_bus_pkg;

    typedef struct packed {
        logic              valid;
        sv32_pkg::access_e acc;
        sv32_pkg::vaddr_t  vaddr;
    } mmu_req_t;

    typedef struct packed {
        logic                      done;
        logic                      fault;
        logic [3:0]                cause;
        logic [sv32_pkg::XLEN-1:0] paddr;
    } mmu_resp_t;

    // satp and mstatus fields seen by the MMU
    typedef struct packed {
        logic                       sv32_on;
        logic [sv32_pkg::PPN_W-1:0] root_ppn;
        sv32_pkg::priv_e            priv;
        logic                       sum;
        logic                       mxr;
    } mmu_csr_t;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [sv32_pkg::XLEN-1:0] paddr;
        logic [sv32_pkg::XLEN-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic                      pready;
        logic [sv32_pkg::XLEN-1:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic                         we;
        sv32_pkg::access_e            acc;
        logic [2*sv32_pkg::VPN_W-1:0] vpn;
        logic [sv32_pkg::PPN_W-1:0]   ppn;
    } tlb_fill_t;

endpackage

// ==== src/tlb_cache.sv ====
// direct-mapped TLB
module tlb_cache #(
    parameter int ENTRIES = sv32_pkg::TLB_ENTRIES
) (
    input  logic                         CLK,
    input  logic                         i_rst_n,
    input  logic                         i_flush,
    input  logic                         i_we,
    input  logic [2*sv32_pkg::VPN_W-1:0] i_wvpn,
    input  logic [sv32_pkg::PPN_W-1:0]   i_wppn,
    input  logic [2*sv32_pkg::VPN_W-1:0] i_rvpn,
    output logic [sv32_pkg::PPN_W-1:0]   o_rppn,
    output logic                         o_hit
);
    import sv32_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 2 * VPN_W - IDX_W;

    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_mem [ENTRIES];
    logic [PPN_W-1:0]   ppn_mem [ENTRIES];
    logic [IDX_W-1:0]   ridx;
    logic [IDX_W-1:0]   widx;
    logic [TAG_W-1:0]   rtag;
    logic [TAG_W-1:0]   wtag;

    // low vpn bits pick the slot
    assign {rtag, ridx} = i_rvpn;
    assign {wtag, widx} = i_wvpn;

    assign o_hit  = valid_q[ridx] && (tag_mem[ridx] == rtag);
    assign o_rppn = ppn_mem[ridx];

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_flush) begin
            valid_q <= '0;
        end else if (i_we) begin
            valid_q[widx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (i_we) begin
            tag_mem[widx] <= wtag;
            ppn_mem[widx] <= i_wppn;
        end
    end

    // fills only happen mid-request, flushes only between requests
    assert property (@(posedge CLK) disable iff (!i_rst_n) !(i_we && i_flush));

endmodule

// ==== src/pte_check.sv ====
// Sv32 PTE permission check
module pte_check (
    input  sv32_pkg::pte_t        i_pte,
    input  logic                  i_level,
    input  sv32_pkg::access_e     i_acc,
    input  mmu_bus_pkg::mmu_csr_t i_csr,
    output logic                  o_leaf,
    output logic                  o_fault,
    output logic [3:0]            o_cause,
    output logic                  o_need_update,
    output sv32_pkg::pte_t        o_pte_upd
);
    import sv32_pkg::*;

    logic is_store;
    logic rwx_bad;
    logic priv_bad;
    logic perm_ok;

    assign is_store = (i_acc == ACC_STORE);
    assign o_leaf   = i_pte.v && (i_pte.r || i_pte.x);
    assign rwx_bad  = i_pte.w && !i_pte.r;

    // user pages need SUM from S, supervisor pages closed to U
    assign priv_bad = ((i_csr.priv == PRIV_S) && i_pte.u && !i_csr.sum) ||
                      ((i_csr.priv == PRIV_U) && !i_pte.u);

    always_comb begin
        case (i_acc)
            ACC_FETCH: perm_ok = i_pte.x;
            ACC_STORE: perm_ok = i_pte.w;
            default:   perm_ok = i_pte.r || (i_pte.x && i_csr.mxr);
        endcase
    end

    // pointer at level 0 has nowhere left to go
    assign o_fault = !i_pte.v || rwx_bad || (!o_leaf && !i_level) ||
                     (o_leaf && (priv_bad || !perm_ok));

    always_comb begin
        case (i_acc)
            ACC_FETCH: o_cause = CAUSE_FETCH_PF;
            ACC_STORE: o_cause = CAUSE_STORE_PF;
            default:   o_cause = CAUSE_LOAD_PF;
        endcase
    end

    assign o_need_update = o_leaf && !o_fault && (!i_pte.a || (is_store && !i_pte.d));

    always_comb begin
        o_pte_upd   = i_pte;
        o_pte_upd.a = 1'b1;
        if (is_store) begin
            o_pte_upd.d = 1'b1;
        end
    end

endmodule

// ==== src/xlate_decode.sv ====
// request decode, TLB lookup and response
module xlate_decode (
    input  logic                   CLK,
    input  logic                   i_rst_n,
    input  mmu_bus_pkg::mmu_req_t  i_req,
    input  mmu_bus_pkg::mmu_csr_t  i_csr,
    input  logic                   i_flush,
    input  mmu_bus_pkg::mmu_resp_t i_walk_resp,
    input  mmu_bus_pkg::tlb_fill_t i_fill,
    output logic                   o_walk_start,
    output mmu_bus_pkg::mmu_resp_t o_resp
);
    import sv32_pkg::*;

    logic             busy_q;
    logic             done_q;
    logic [XLEN-1:0]  paddr_q;
    logic             accept;
    logic             bare;
    logic [2:0]       tlb_hit;
    logic [PPN_W-1:0] tlb_ppn [3];
    logic [1:0]       sel;
    logic             lk_hit;
    logic [PPN_W-1:0] lk_ppn;

    // one TLB per access type, slot g serves access_e value g
    for (genvar g = 0; g < 3; g++) begin : g_tlb
        tlb_cache u_tlb (
            .CLK     (CLK),
            .i_rst_n (i_rst_n),
            .i_flush (i_flush),
            .i_we    (i_fill.we && (i_fill.acc == access_e'(g))),
            .i_wvpn  (i_fill.vpn),
            .i_wppn  (i_fill.ppn),
            .i_rvpn  ({i_req.vaddr.vpn1, i_req.vaddr.vpn0}),
            .o_rppn  (tlb_ppn[g]),
            .o_hit   (tlb_hit[g])
        );
    end

    assign sel    = (i_req.acc == ACC_STORE) ? 2'd2 : (i_req.acc == ACC_LOAD) ? 2'd1 : 2'd0;
    assign lk_hit = tlb_hit[sel];
    assign lk_ppn = tlb_ppn[sel];

    assign bare         = (i_csr.priv == PRIV_M) || !i_csr.sv32_on;
    assign accept       = i_req.valid && !busy_q;
    assign o_walk_start = accept && !bare && !lk_hit;

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= accept && (bare || lk_hit);
            if (accept) begin
                busy_q <= 1'b1;
            end else if (o_resp.done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            paddr_q <= bare ? i_req.vaddr : {lk_ppn, i_req.vaddr.offset};
        end
    end

    // local answer wins, otherwise pass the walker through
    always_comb begin
        if (done_q) begin
            o_resp = '{done: 1'b1, fault: 1'b0, cause: 4'd0, paddr: paddr_q};
        end else begin
            o_resp = i_walk_resp;
        end
    end

    assert property (@(posedge CLK) disable iff (!i_rst_n) o_resp.done |=> !o_resp.done);

endmodule

// ==== src/page_walker.sv ====
// two-level Sv32 page-table walker
module page_walker (
    input  logic                   CLK,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    input  mmu_bus_pkg::mmu_req_t  i_req,
    input  mmu_bus_pkg::mmu_csr_t  i_csr,
    input  mmu_bus_pkg::apb_rsp_t  i_apb,
    output mmu_bus_pkg::apb_req_t  o_apb,
    output mmu_bus_pkg::mmu_resp_t o_resp,
    output mmu_bus_pkg::tlb_fill_t o_fill
);
    import sv32_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_SETUP,
        ST_RD_ACCESS,
        ST_EVAL,
        ST_WR_SETUP,
        ST_WR_ACCESS
    } state_e;

    state_e          state_q;
    logic            level_q;
    logic [XLEN-1:0] addr_q;
    pte_t            pte_q;
    logic            done_q;
    logic            fault_q;
    logic [3:0]      cause_q;
    logic [XLEN-1:0] paddr_q;
    logic            leaf;
    logic            fault;
    logic [3:0]      cause;
    logic            need_upd;
    pte_t            pte_upd;
    logic [XLEN-1:0] leaf_paddr;

    pte_check u_check (
        .i_pte         (pte_q),
        .i_level       (level_q),
        .i_acc         (i_req.acc),
        .i_csr         (i_csr),
        .o_leaf        (leaf),
        .o_fault       (fault),
        .o_cause       (cause),
        .o_need_update (need_upd),
        .o_pte_upd     (pte_upd)
    );

    // megapage keeps vpn0 from the virtual address
    assign leaf_paddr = level_q ?
        {pte_q.ppn[PPN_W-1:VPN_W], i_req.vaddr.vpn0, i_req.vaddr.offset} :
        {pte_q.ppn, i_req.vaddr.offset};

    always_ff @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
            fault_q <= 1'b0;
            cause_q <= 4'd0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE:      if (i_start) state_q <= ST_RD_SETUP;
                ST_RD_SETUP:  state_q <= ST_RD_ACCESS;
                ST_RD_ACCESS: if (i_apb.pready) state_q <= ST_EVAL;
                ST_EVAL: begin
                    fault_q <= fault;
                    cause_q <= cause;
                    if (!fault && !leaf) begin
                        state_q <= ST_RD_SETUP;
                    end else if (need_upd) begin
                        state_q <= ST_WR_SETUP;
                    end else begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                ST_WR_SETUP:  state_q <= ST_WR_ACCESS;
                ST_WR_ACCESS: begin
                    if (i_apb.pready) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end
                end
                default:      state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == ST_IDLE && i_start) begin
            level_q <= 1'b1;
            addr_q  <= {i_csr.root_ppn, i_req.vaddr.vpn1, 2'b00};
        end
        if (state_q == ST_RD_ACCESS && i_apb.pready) begin
            pte_q <= i_apb.prdata;
        end
        if (state_q == ST_EVAL) begin
            paddr_q <= leaf_paddr;
            if (!fault && !leaf) begin
                level_q <= 1'b0;
                addr_q  <= {pte_q.ppn, i_req.vaddr.vpn0, 2'b00};
            end
            // written back from pte_q, addr_q still points at it
            if (need_upd) begin
                pte_q <= pte_upd;
            end
        end
    end

    always_comb begin
        o_apb.psel    = state_q inside {ST_RD_SETUP, ST_RD_ACCESS, ST_WR_SETUP, ST_WR_ACCESS};
        o_apb.penable = state_q inside {ST_RD_ACCESS, ST_WR_ACCESS};
        o_apb.pwrite  = state_q inside {ST_WR_SETUP, ST_WR_ACCESS};
        o_apb.paddr   = addr_q;
        o_apb.pwdata  = pte_q;
    end

    always_comb begin
        o_resp = '{done: done_q, fault: fault_q, cause: cause_q, paddr: paddr_q};
        o_fill = '{we: done_q && !fault_q, acc: i_req.acc,
                   vpn: {i_req.vaddr.vpn1, i_req.vaddr.vpn0},
                   ppn: paddr_q[XLEN-1:PAGE_OFS_W]};
    end

    assert property (@(posedge CLK) disable iff (!i_rst_n)
        (o_apb.penable && !i_apb.pready) |=> $stable(o_apb));

endmodule

// ==== src/mmu_top.sv ====
// Sv32 MMU top level
module mmu_top (
    input  logic                   CLK,
    input  logic                   i_rst_n,
    input  mmu_bus_pkg::mmu_req_t  i_req,
    input  mmu_bus_pkg::mmu_csr_t  i_csr,
    input  logic                   i_flush,
    input  mmu_bus_pkg::apb_rsp_t  i_apb,
    output mmu_bus_pkg::mmu_resp_t o_resp,
    output mmu_bus_pkg::apb_req_t  o_apb
);
    import mmu_bus_pkg::*;

    logic      walk_start;
    mmu_resp_t walk_resp;
    tlb_fill_t fill;

    xlate_decode u_decode (
        .CLK          (CLK),
        .i_rst_n      (i_rst_n),
        .i_req        (i_req),
        .i_csr        (i_csr),
        .i_flush      (i_flush),
        .i_walk_resp  (walk_resp),
        .i_fill       (fill),
        .o_walk_start (walk_start),
        .o_resp       (o_resp)
    );

    // misses only
    page_walker u_walker (
        .CLK     (CLK),
        .i_rst_n (i_rst_n),
        .i_start (walk_start),
        .i_req   (i_req),
        .i_csr   (i_csr),
        .i_apb   (i_apb),
        .o_apb   (o_apb),
        .o_resp  (walk_resp),
        .o_fill  (fill)
    );

endmodule

// ==== sim/apb_mem_model.sv ====
// APB page-table memory
module apb_mem_model (
    input  logic                  CLK,
    input  logic                  i_rst_n,
    input  mmu_bus_pkg::apb_req_t i_apb,
    output mmu_bus_pkg::apb_rsp_t o_apb
);
    logic [31:0] mem [4096];
    logic [15:0] lfsr_q;
    logic        rdy_q;
    int          rd_count;
    int          wr_count;
    logic [31:0] rd_addr [$];
    logic [31:0] wr_addr [$];
    logic [31:0] wr_data [$];

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = '0;
        end
    end

    assign o_apb.pready = rdy_q;
    assign o_apb.prdata = mem[i_apb.paddr[13:2]];

    always @(posedge CLK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lfsr_q   <= 16'd47856;
            rdy_q    <= 1'b0;
            rd_count <= 0;
            wr_count <= 0;
        end else if (i_apb.psel && i_apb.penable && rdy_q) begin
            rdy_q <= 1'b0;
            if (i_apb.pwrite) begin
                mem[i_apb.paddr[13:2]] = i_apb.pwdata;
                wr_count <= wr_count + 1;
                wr_addr.push_back(i_apb.paddr);
                wr_data.push_back(i_apb.pwdata);
            end else begin
                rd_count <= rd_count + 1;
                rd_addr.push_back(i_apb.paddr);
            end
        end else if (i_apb.psel) begin
            // one bit per cycle, a set bit stalls
            rdy_q  <= !lfsr_q[0];
            lfsr_q <= lfsr_step(lfsr_q);
        end
    end

endmodule

// ==== sim/tb_mmu.sv ====
// Sv32 MMU testbench
module tb_mmu;
    import sv32_pkg::*;
    import mmu_bus_pkg::*;

    localparam int          TIMEOUT  = 500;
    localparam logic [19:0] ROOT_PPN = 20'h00001;
    localparam logic [19:0] L0_PPN   = 20'h00002;
    localparam logic [19:0] MEGA_PPN = 20'h0C800;
    localparam logic [19:0] PAGE_PPN = 20'h12345;
    localparam logic [19:0] RO_PPN   = 20'h00777;
    localparam logic [19:0] USER_PPN = 20'h00ABC;
    // pte flag bits
    localparam logic [7:0] F_V = 8'h01;
    localparam logic [7:0] F_R = 8'h02;
    localparam logic [7:0] F_W = 8'h04;
    localparam logic [7:0] F_X = 8'h08;
    localparam logic [7:0] F_U = 8'h10;
    localparam logic [7:0] F_A = 8'h40;
    localparam logic [7:0] F_D = 8'h80;

    logic      CLK;
    logic      i_rst_n;
    mmu_req_t  req;
    mmu_csr_t  csr;
    logic      flush;
    mmu_resp_t resp;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    int        rd0;
    int        wr0;

    mmu_top dut (
        .CLK     (CLK),
        .i_rst_n (i_rst_n),
        .i_req   (req),
        .i_csr   (csr),
        .i_flush (flush),
        .i_apb   (apb_rsp),
        .o_resp  (resp),
        .o_apb   (apb_req)
    );

    apb_mem_model u_mem (
        .CLK     (CLK),
        .i_rst_n (i_rst_n),
        .i_apb   (apb_req),
        .o_apb   (apb_rsp)
    );

    always #5 CLK = ~CLK;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] make_pte(input logic [19:0] ppn, input logic [7:0] flags);
        return {2'b00, ppn, 2'b00, flags};
    endfunction

    // entry address is table base page plus four bytes per index
    function automatic logic [31:0] pte_addr(input logic [19:0] base, input logic [9:0] vpn);
        return {12'd0, base} * 32'd4096 + {22'd0, vpn} * 32'd4;
    endfunction

    task automatic set_csr(input priv_e priv, input logic on, input logic sum);
        csr = '{sv32_on: on, root_ppn: ROOT_PPN, priv: priv, sum: sum, mxr: 1'b0};
    endtask

    task automatic mark_counts();
        rd0 = u_mem.rd_count;
        wr0 = u_mem.wr_count;
    endtask

    task automatic check_xfers(input int rds, input int wrs);
        check("apb reads", u_mem.rd_count - rd0, rds);
        check("apb writes", u_mem.wr_count - wr0, wrs);
    endtask

    task automatic translate(input access_e acc, input logic [31:0] va,
                             output mmu_resp_t r, output int cycles);
        int n;
        n = 0;
        r = '0;
        @(posedge CLK);
        #1;
        req = '{valid: 1'b1, acc: acc, vaddr: va};
        while (!r.done) begin
            @(posedge CLK);
            #1;
            n++;
            if (resp.done) begin
                r = resp;
            end else if (n >= TIMEOUT) begin
                abort_run("no response from the MMU within the timeout");
            end
        end
        req.valid = 1'b0;
        cycles = n;
    endtask

    task automatic build_tables();
        u_mem.mem[pte_addr(ROOT_PPN, 10'd1) >> 2] = make_pte(L0_PPN, F_V);
        u_mem.mem[pte_addr(ROOT_PPN, 10'd2) >> 2] = make_pte(MEGA_PPN, F_V | F_X | F_A);
        u_mem.mem[pte_addr(L0_PPN, 10'd3) >> 2] = make_pte(PAGE_PPN, F_V | F_R | F_W);
        u_mem.mem[pte_addr(L0_PPN, 10'd4) >> 2] = make_pte(RO_PPN, F_V | F_R | F_A | F_D);
        u_mem.mem[pte_addr(L0_PPN, 10'd5) >> 2] = make_pte(USER_PPN, F_V | F_R | F_U | F_A);
    endtask

    task automatic bare_mode();
        mmu_resp_t r;
        int        n;
        set_csr(PRIV_M, 1'b1, 1'b0);
        mark_counts();
        translate(ACC_LOAD, 32'h8000_1234, r, n);
        check("bare paddr", r.paddr, 32'h8000_1234);
        check("bare latency", n, 1);
        // S mode with translation off is bare too
        set_csr(PRIV_S, 1'b0, 1'b0);
        translate(ACC_STORE, 32'h0040_3234, r, n);
        check("bare paddr", r.paddr, 32'h0040_3234);
        check("bare fault", r.fault, 0);
        check_xfers(0, 0);
    endtask

    task automatic walk_load_store();
        mmu_resp_t r;
        int        n;
        set_csr(PRIV_S, 1'b1, 1'b0);
        mark_counts();
        translate(ACC_LOAD, {10'd1, 10'd3, 12'h234}, r, n);
        check("walk fault", r.fault, 0);
        check("walk paddr", r.paddr, {PAGE_PPN, 12'h234});
        check_xfers(2, 1);
        check("l1 read addr", u_mem.rd_addr[rd0], pte_addr(ROOT_PPN, 10'd1));
        check("l0 read addr", u_mem.rd_addr[rd0 + 1], pte_addr(L0_PPN, 10'd3));
        check("a write addr", u_mem.wr_addr[wr0], pte_addr(L0_PPN, 10'd3));
        check("a write data", u_mem.wr_data[wr0], make_pte(PAGE_PPN, F_V | F_R | F_W | F_A));
        mark_counts();
        translate(ACC_STORE, {10'd1, 10'd3, 12'h234}, r, n);
        check("store fault", r.fault, 0);
        check("store paddr", r.paddr, {PAGE_PPN, 12'h234});
        check_xfers(2, 1);
        check("d write addr", u_mem.wr_addr[wr0], pte_addr(L0_PPN, 10'd3));
        check("d write data", u_mem.wr_data[wr0],
              make_pte(PAGE_PPN, F_V | F_R | F_W | F_A | F_D));
    endtask

    task automatic megapage_fetch();
        mmu_resp_t   r;
        int          n;
        logic [31:0] va;
        va = {10'd2, 10'h155, 12'hABC};
        mark_counts();
        translate(ACC_FETCH, va, r, n);
        check("mega fault", r.fault, 0);
        check("mega paddr", r.paddr, {MEGA_PPN[19:10], va[21:0]});
        check_xfers(1, 0);
        check("mega read addr", u_mem.rd_addr[rd0], pte_addr(ROOT_PPN, 10'd2));
    endtask

    task automatic tlb_hit_flush();
        mmu_resp_t r;
        int        n;
        mark_counts();
        translate(ACC_LOAD, {10'd1, 10'd3, 12'h0C8}, r, n);
        check("hit paddr", r.paddr, {PAGE_PPN, 12'h0C8});
        check("hit latency", n, 1);
        check_xfers(0, 0);
        @(posedge CLK);
        #1;
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        mark_counts();
        translate(ACC_LOAD, {10'd1, 10'd3, 12'h0C8}, r, n);
        check("flushed paddr", r.paddr, {PAGE_PPN, 12'h0C8});
        check_xfers(2, 0);
    endtask

    task automatic page_faults();
        mmu_resp_t r;
        int        n;
        mark_counts();
        translate(ACC_STORE, {10'd1, 10'd4, 12'h010}, r, n);
        check("ro store fault", r.fault, 1);
        check("ro store cause", r.cause, 15);
        translate(ACC_FETCH, {10'd1, 10'd4, 12'h010}, r, n);
        check("nx fetch fault", r.fault, 1);
        check("nx fetch cause", r.cause, 12);
        check_xfers(4, 0);
        translate(ACC_LOAD, {10'd1, 10'd5, 12'h0F0}, r, n);
        check("user load fault", r.fault, 1);
        check("user load cause", r.cause, 13);
        set_csr(PRIV_S, 1'b1, 1'b1);
        translate(ACC_LOAD, {10'd1, 10'd5, 12'h0F0}, r, n);
        check("sum load fault", r.fault, 0);
        check("sum load paddr", r.paddr, {USER_PPN, 12'h0F0});
        set_csr(PRIV_S, 1'b1, 1'b0);
        // level-1 slot 3 holds a zero entry
        translate(ACC_FETCH, {10'd3, 10'd0, 12'h000}, r, n);
        check("invalid fetch fault", r.fault, 1);
        check("invalid fetch cause", r.cause, 12);
        translate(ACC_LOAD, {10'd3, 10'd0, 12'h000}, r, n);
        check("invalid load fault", r.fault, 1);
        check("invalid load cause", r.cause, 13);
        translate(ACC_STORE, {10'd3, 10'd0, 12'h000}, r, n);
        check("invalid store fault", r.fault, 1);
        check("invalid store cause", r.cause, 15);
    endtask

    initial begin
        CLK     = 1'b0;
        i_rst_n = 1'b0;
        req     = '0;
        csr     = '0;
        flush   = 1'b0;
        rd0     = 0;
        wr0     = 0;
        repeat (5) @(posedge CLK);
        #1;
        i_rst_n = 1'b1;
        check("o_resp.done", resp.done, 0);
        check("psel", apb_req.psel, 0);
        check("penable", apb_req.penable, 0);
        build_tables();
        bare_mode();
        walk_load_store();
        megapage_fetch();
        tlb_hit_flush();
        page_faults();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
src/sv32_pkg.sv
src/mmu_bus_pkg.sv
src/tlb_cache.sv
src/pte_check.sv
src/xlate_decode.sv
src/page_walker.sv
src/mmu_top.sv
sim/apb_mem_model.sv
sim/tb_mmu.sv
